// ==== design/ecp_pkg.sv ====
/*
 * P-256 point sequencer package
 * MAS operation codes, working-bank addressing and the packed
 * records for one program step and one MAS request
 */
`default_nettype none

package ecp_pkg;

   // MAS mode encoding as seen on the mode lines
   typedef enum logic [1:0] {
      MAS_INT = 2'd0,   // integer add/sub
      MAS_SUB = 2'd1,
      MAS_ADD = 2'd2,
      MAS_MUL = 2'd3
   } mas_op_e;

   typedef logic [2:0] reg_idx_t;    // t_n sits at index n-1
   typedef logic [4:0] ext_addr_t;
   typedef logic [4:0] step_idx_t;

   localparam logic [1:0] REG_BANK = 2'd2;   // working bank is 16..23

   localparam int unsigned DBL_LEN = 22;
   localparam int unsigned ADD_LEN = 26;

   typedef struct packed {
      mas_op_e  op;
      reg_idx_t src1;
      reg_idx_t src2;
      reg_idx_t dst;
   } step_t;

   typedef struct packed {
      logic      start;
      mas_op_e   mode;
      ext_addr_t raddr1;
      ext_addr_t raddr2;
      ext_addr_t waddr;
   } mas_req_t;

endpackage

`default_nettype wire

// ==== design/ecp_step_rom.sv ====
/*
 * point operation step ROM
 * holds the Jacobian doubling (22 steps) and addition (26 steps)
 * programs as constant tables; combinational, no latency
 * an index past the end of a program reads as an all-zero step
 */
`timescale 1ns/1ps
`default_nettype none

module ecp_step_rom (
   input  logic               is_add,
   input  ecp_pkg::step_idx_t step_idx,
   output ecp_pkg::step_t     step
);
   import ecp_pkg::*;

   step_t dbl_step;
   step_t add_step;

   // operands given as register numbers t1..t7
   function automatic step_t op_step(input mas_op_e op, input int unsigned a,
                                     input int unsigned b, input int unsigned d);
      step_t s;
      s.op   = op;
      s.src1 = reg_idx_t'(a - 1);
      s.src2 = reg_idx_t'(b - 1);
      s.dst  = reg_idx_t'(d - 1);
      return s;
   endfunction

   // doubling program with X,Y,Z in t1,t2,t3 on entry
   always_comb begin
      dbl_step = '0;
      case (step_idx)
         5'd0:  dbl_step = op_step(MAS_MUL, 3, 3, 4);   // t4 = t3^2
         5'd1:  dbl_step = op_step(MAS_SUB, 1, 4, 5);
         5'd2:  dbl_step = op_step(MAS_ADD, 1, 4, 4);
         5'd3:  dbl_step = op_step(MAS_MUL, 4, 5, 5);
         5'd4:  dbl_step = op_step(MAS_ADD, 5, 5, 4);
         5'd5:  dbl_step = op_step(MAS_ADD, 4, 5, 4);   // 3*(x-z^2)(x+z^2)
         5'd6:  dbl_step = op_step(MAS_MUL, 3, 2, 3);
         5'd7:  dbl_step = op_step(MAS_ADD, 3, 3, 3);   // z3 done
         5'd8:  dbl_step = op_step(MAS_MUL, 2, 2, 2);
         5'd9:  dbl_step = op_step(MAS_MUL, 1, 2, 5);
         5'd10: dbl_step = op_step(MAS_ADD, 5, 5, 5);
         5'd11: dbl_step = op_step(MAS_ADD, 5, 5, 5);   // 4*x*y^2
         5'd12: dbl_step = op_step(MAS_MUL, 4, 4, 1);
         5'd13: dbl_step = op_step(MAS_SUB, 1, 5, 1);
         5'd14: dbl_step = op_step(MAS_SUB, 1, 5, 1);   // x3 done
         5'd15: dbl_step = op_step(MAS_MUL, 2, 2, 2);
         5'd16: dbl_step = op_step(MAS_ADD, 2, 2, 2);
         5'd17: dbl_step = op_step(MAS_ADD, 2, 2, 2);
         5'd18: dbl_step = op_step(MAS_ADD, 2, 2, 2);   // 8*y^4
         5'd19: dbl_step = op_step(MAS_SUB, 5, 1, 5);
         5'd20: dbl_step = op_step(MAS_MUL, 5, 4, 5);
         5'd21: dbl_step = op_step(MAS_SUB, 5, 2, 2);   // y3 done
         default: dbl_step = '0;
      endcase
   end

   // addition program with the second point's z in t6
   always_comb begin
      add_step = '0;
      case (step_idx)
         5'd0:  add_step = op_step(MAS_MUL, 6, 6, 7);
         5'd1:  add_step = op_step(MAS_MUL, 1, 7, 1);
         5'd2:  add_step = op_step(MAS_MUL, 6, 7, 7);
         5'd3:  add_step = op_step(MAS_MUL, 2, 7, 2);
         5'd4:  add_step = op_step(MAS_MUL, 3, 3, 7);
         5'd5:  add_step = op_step(MAS_MUL, 4, 7, 4);
         5'd6:  add_step = op_step(MAS_MUL, 3, 7, 7);
         5'd7:  add_step = op_step(MAS_MUL, 5, 7, 5);
         5'd8:  add_step = op_step(MAS_SUB, 1, 4, 4);   // w
         5'd9:  add_step = op_step(MAS_SUB, 2, 5, 5);   // r
         5'd10: add_step = op_step(MAS_ADD, 1, 1, 1);
         5'd11: add_step = op_step(MAS_SUB, 1, 4, 1);
         5'd12: add_step = op_step(MAS_ADD, 2, 2, 2);
         5'd13: add_step = op_step(MAS_SUB, 2, 5, 2);
         5'd14: add_step = op_step(MAS_MUL, 3, 6, 3);
         5'd15: add_step = op_step(MAS_MUL, 3, 4, 3);   // z3 done
         5'd16: add_step = op_step(MAS_MUL, 4, 4, 7);
         5'd17: add_step = op_step(MAS_MUL, 4, 7, 4);
         5'd18: add_step = op_step(MAS_MUL, 1, 7, 7);
         5'd19: add_step = op_step(MAS_MUL, 5, 5, 1);
         5'd20: add_step = op_step(MAS_SUB, 1, 7, 1);   // x3 done
         5'd21: add_step = op_step(MAS_SUB, 7, 1, 7);
         5'd22: add_step = op_step(MAS_SUB, 7, 1, 7);
         5'd23: add_step = op_step(MAS_MUL, 5, 7, 5);
         5'd24: add_step = op_step(MAS_MUL, 2, 4, 4);
         5'd25: add_step = op_step(MAS_SUB, 5, 4, 2);   // 2*y3 before halving
         default: add_step = '0;
      endcase
   end

   assign step = is_add ? add_step : dbl_step;

endmodule

`default_nettype wire

// ==== design/ecp_seq_fsm.sv ====
/*
 * point operation sequencer FSM
 * walks one program of the step ROM, issues one MAS request per
 * step and waits for mas_done before moving on; done pulses for one
 * cycle after the last step. start is only accepted while idle
 */
`timescale 1ns/1ps
`default_nettype none

module ecp_seq_fsm (
   input  logic               clk,
   input  logic               resetn,
   input  logic               start,
   input  logic               ad,
   input  logic               mas_done,
   input  ecp_pkg::step_t     step,
   output logic               is_add,
   output ecp_pkg::step_idx_t step_idx,
   output ecp_pkg::mas_req_t  mas_req,
   output logic               done
);
   import ecp_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      ISSUE,
      WAIT,
      NEXT,
      FINISH
   } state_e;

   state_e state;
   logic   last_step;
   logic   issue;
   logic   mas_ack;

   assign last_step = is_add ? (step_idx == step_idx_t'(ADD_LEN - 1))
                             : (step_idx == step_idx_t'(DBL_LEN - 1));

   // first step leaves from ISSUE, the others from NEXT
   assign issue = (state == ISSUE) || (state == NEXT);

   // a done still high from the previous step is not looked at in the start cycle
   assign mas_ack = mas_done && !mas_req.start;

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         state    <= IDLE;
         step_idx <= '0;
         is_add   <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  step_idx <= '0;
                  is_add   <= ad;   // program chosen for the whole run
                  state    <= ISSUE;
               end
            end
            ISSUE, NEXT: begin
               state <= WAIT;
            end
            WAIT: begin
               if (mas_ack) begin
                  if (last_step) begin
                     state <= FINISH;
                  end else begin
                     step_idx <= step_idx + 1'b1;
                     state    <= NEXT;
                  end
               end
            end
            FINISH: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         mas_req <= '0;
         done    <= 1'b0;
      end else begin
         mas_req.start <= issue;   // one cycle per step
         done          <= (state == FINISH);
         if (issue) begin
            mas_req.mode   <= step.op;
            mas_req.raddr1 <= {REG_BANK, step.src1};
            mas_req.raddr2 <= {REG_BANK, step.src2};
            mas_req.waddr  <= {REG_BANK, step.dst};
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/ecp_point_seq.sv ====
/*
 * P-256 Jacobian point add/double sequencer
 * step ROM plus sequencer FSM driving an external MAS
 */
`timescale 1ns/1ps
`default_nettype none

module ecp_point_seq (
   input  logic              clk,
   input  logic              resetn,
   input  logic              start,
   input  logic              ad,         // high selects addition
   input  logic              mas_done,
   output ecp_pkg::mas_req_t mas_req,
   output logic              done
);
   import ecp_pkg::*;

   logic      is_add;
   step_idx_t step_idx;
   step_t     step;

   ecp_step_rom ecp_step_rom_inst (
      .is_add   (is_add),
      .step_idx (step_idx),
      .step     (step)
   );

   ecp_seq_fsm ecp_seq_fsm_inst (
      .clk      (clk),
      .resetn   (resetn),
      .start    (start),
      .ad       (ad),
      .mas_done (mas_done),
      .step     (step),
      .is_add   (is_add),
      .step_idx (step_idx),
      .mas_req  (mas_req),
      .done     (done)
   );

endmodule

`default_nettype wire

// ==== dv/mas_model.sv ====
/*
 * behavioral MAS responder
 * answers each request with a one-cycle mas_done after a random delay,
 * counts requests per mode, logs their addresses and checks that the
 * request fields hold while it works
 */
`timescale 1ns/1ps
`default_nettype none

module mas_model (
   input  logic              clk,
   input  logic              resetn,
   input  ecp_pkg::mas_req_t mas_req,
   output logic              mas_done
);
   import ecp_pkg::*;

   integer    seed;
   int        req_count;
   int        mul_count;
   int        add_count;
   int        sub_count;
   int        max_delay;
   int        err_count;
   int        wait_cnt;
   logic      busy;
   logic      rst_smp;
   mas_req_t  req_smp;
   mas_req_t  held;
   ext_addr_t raddr1_log [0:31];
   ext_addr_t raddr2_log [0:31];
   ext_addr_t waddr_log  [0:31];

   task automatic clear_stats();
      req_count = 0;
      mul_count = 0;
      add_count = 0;
      sub_count = 0;
      max_delay = 0;
   endtask

   initial begin
      seed      = 69;
      err_count = 0;
      busy      = 1'b0;
      mas_done  = 1'b0;
      wait_cnt  = 0;
      clear_stats();
      forever begin
         @(posedge clk);
         rst_smp = resetn;   // values before the DUT updates
         req_smp = mas_req;
         #1;
         if (!rst_smp) begin
            busy     = 1'b0;
            mas_done = 1'b0;
         end else if (req_smp.start) begin
            held     = req_smp;
            busy     = 1'b1;
            mas_done = 1'b0;
            wait_cnt = 1 + ($unsigned($random(seed)) % 20);
            if (wait_cnt > max_delay) begin
               max_delay = wait_cnt;
            end
            if (req_count < 32) begin
               raddr1_log[req_count] = req_smp.raddr1;
               raddr2_log[req_count] = req_smp.raddr2;
               waddr_log[req_count]  = req_smp.waddr;
            end
            req_count++;
            case (req_smp.mode)
               MAS_MUL: mul_count++;
               MAS_ADD: add_count++;
               MAS_SUB: sub_count++;
               default: ;
            endcase
         end else if (busy) begin
            assert (req_smp[16:0] == held[16:0]) else begin
               $display("FAILED t=%0t mas_req fields: got %h expected %h",
                        $time, req_smp[16:0], held[16:0]);
               err_count++;
            end
            if (mas_done) begin
               mas_done = 1'b0;   // one-cycle completion
               busy     = 1'b0;
            end else if (wait_cnt <= 1) begin
               mas_done = 1'b1;
            end else begin
               wait_cnt--;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/ecp_point_seq_asserts.sv ====
/*
 * point sequencer protocol assertions
 * single-cycle request and done pulses, request fields held
 * from mas_req.start until mas_done
 */
`timescale 1ns/1ps
`default_nettype none

module ecp_point_seq_asserts (
   input logic              clk,
   input logic              resetn,
   input ecp_pkg::mas_req_t mas_req,
   input logic              mas_done,
   input logic              done
);

   int          fail_count;
   logic        waiting;
   logic [16:0] fields;

   initial fail_count = 0;

   assign fields = {mas_req.mode, mas_req.raddr1, mas_req.raddr2, mas_req.waddr};

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         waiting <= 1'b0;
      end else if (mas_req.start) begin
         waiting <= 1'b1;
      end else if (mas_done) begin
         waiting <= 1'b0;   // request retired
      end
   end

   a_single_start: assert property (@(posedge clk) disable iff (!resetn)
      mas_req.start |=> !mas_req.start)
      else begin
         $error("mas_req.start high in two consecutive cycles");
         fail_count++;
      end

   a_single_done: assert property (@(posedge clk) disable iff (!resetn)
      done |=> !done)
      else begin
         $error("done high for more than one cycle");
         fail_count++;
      end

   a_fields_held: assert property (@(posedge clk) disable iff (!resetn)
      waiting |-> $stable(fields))
      else begin
         $error("mode or address changed while the MAS was busy");
         fail_count++;
      end

endmodule

bind ecp_point_seq ecp_point_seq_asserts ecp_point_seq_asserts_inst (
   .clk      (clk),
   .resetn   (resetn),
   .mas_req  (mas_req),
   .mas_done (mas_done),
   .done     (done)
);

`default_nettype wire

// ==== include/tb_params.svh ====
/*
 * point sequencer testbench constants
 * expected request and mode counts, end-step addresses, timeout
 */
`ifndef TB_PARAMS_SVH
`define TB_PARAMS_SVH

localparam int EXP_DBL_REQS = 22;
localparam int EXP_DBL_MUL  = 8;
localparam int EXP_DBL_ADD  = 9;
localparam int EXP_DBL_SUB  = 5;

localparam int EXP_ADD_REQS = 26;
localparam int EXP_ADD_MUL  = 16;
localparam int EXP_ADD_ADD  = 2;
localparam int EXP_ADD_SUB  = 8;

localparam logic [4:0] DBL_FIRST_RADDR1 = 5'd18;
localparam logic [4:0] DBL_FIRST_RADDR2 = 5'd18;
localparam logic [4:0] DBL_FIRST_WADDR  = 5'd19;
localparam logic [4:0] DBL_LAST_RADDR1  = 5'd20;
localparam logic [4:0] DBL_LAST_RADDR2  = 5'd17;
localparam logic [4:0] DBL_LAST_WADDR   = 5'd17;
localparam logic [4:0] ADD_FIRST_RADDR1 = 5'd21;
localparam logic [4:0] ADD_FIRST_RADDR2 = 5'd21;
localparam logic [4:0] ADD_FIRST_WADDR  = 5'd22;

localparam int NUM_TESTS      = 5;
localparam int TIMEOUT_CYCLES = NUM_TESTS * 48 * 24 + 2000;   // 48 steps of up to 24 cycles

`endif

// ==== dv/tb_ecp_point_seq.sv ====
/*
 * point sequencer testbench
 * runs the doubling and addition programs against a behavioral MAS
 * and checks request counts, end-step addresses, handshake timing,
 * start while busy and reset in the middle of a run
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ecp_point_seq;
   import ecp_pkg::*;
   `include "tb_params.svh"

   localparam int CLK_PERIOD   = 8;
   localparam int EDGES_TO_REQ = 2;   // trigger to next mas_req.start or done
   localparam int RUN_LIMIT    = 26 * 24 + 50;

   logic     clk;
   logic     resetn;
   logic     start;
   logic     ad;
   logic     mas_done;
   mas_req_t mas_req;
   logic     done;

   int   cyc;
   int   trig_cyc;
   logic trig_pend;
   int   done_count;
   int   value_errs;
   int   other_errs;
   int   total_errs;

   ecp_point_seq ecp_point_seq_inst (
      .clk      (clk),
      .resetn   (resetn),
      .start    (start),
      .ad       (ad),
      .mas_done (mas_done),
      .mas_req  (mas_req),
      .done     (done)
   );

   mas_model mas_model_inst (
      .clk      (clk),
      .resetn   (resetn),
      .mas_req  (mas_req),
      .mas_done (mas_done)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   // handshake timing sampled mid-cycle
   always @(negedge clk) begin
      if (!resetn) begin
         trig_pend = 1'b0;
      end else begin
         if (mas_req.start || done) begin
            if (trig_pend) begin
               assert (cyc - trig_cyc == EDGES_TO_REQ) else begin
                  $display("FAILED t=%0t %s delay: got %0d expected %0d", $time,
                           done ? "done" : "mas_req.start", cyc - trig_cyc, EDGES_TO_REQ);
                  value_errs++;
               end
            end
            trig_pend = 1'b0;
         end
         if (done) begin
            done_count++;
         end
         if (mas_done) begin
            trig_pend = 1'b1;
            trig_cyc  = cyc;
         end
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic compare(input string name, input int got, input int exp);
      assert (got == exp) else begin
         $display("FAILED t=%0t %s: got %0d expected %0d", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic reset_dut();
      resetn = 1'b0;
      start  = 1'b0;
      repeat (10) begin
         next_cycle();
         compare("done in reset", done, 0);
         compare("mas_req.start in reset", mas_req.start, 0);
      end
      compare("mas_req fields in reset", int'(mas_req[16:0]), 0);
      resetn = 1'b1;
   endtask

   task automatic launch(input logic add_sel);
      mas_model_inst.clear_stats();
      done_count = 0;
      start      = 1'b1;
      ad         = add_sel;
      trig_pend  = 1'b1;
      trig_cyc   = cyc;
      next_cycle();
      start = 1'b0;
      ad    = 1'b0;
   endtask

   task automatic wait_for_requests(input int n);
      int k;
      k = 0;
      while (mas_model_inst.req_count < n && k < RUN_LIMIT) begin
         next_cycle();
         k++;
      end
   endtask

   task automatic wait_for_done();
      int k;
      k = 0;
      while (done_count == 0 && k < RUN_LIMIT) begin
         next_cycle();
         k++;
      end
      assert (done_count > 0) else begin
         $display("ERROR t=%0t: no done pulse within %0d cycles", $time, RUN_LIMIT);
         other_errs++;
      end
      repeat (4) next_cycle();   // room for a stray second pulse
   endtask

   task automatic check_run(input logic add_sel);
      compare("mas_req.start count", mas_model_inst.req_count,
              add_sel ? EXP_ADD_REQS : EXP_DBL_REQS);
      compare("MAS_MUL requests", mas_model_inst.mul_count, add_sel ? EXP_ADD_MUL : EXP_DBL_MUL);
      compare("MAS_ADD requests", mas_model_inst.add_count, add_sel ? EXP_ADD_ADD : EXP_DBL_ADD);
      compare("MAS_SUB requests", mas_model_inst.sub_count, add_sel ? EXP_ADD_SUB : EXP_DBL_SUB);
      compare("done pulses", done_count, 1);
   endtask

   task automatic run_program(input logic add_sel);
      launch(add_sel);
      wait_for_done();
      check_run(add_sel);
   endtask

   task automatic test_double();
      run_program(1'b0);
   endtask

   task automatic test_add();
      run_program(1'b1);
   endtask

   task automatic test_end_addresses();
      run_program(1'b0);
      compare("first raddr1", mas_model_inst.raddr1_log[0], DBL_FIRST_RADDR1);
      compare("first raddr2", mas_model_inst.raddr2_log[0], DBL_FIRST_RADDR2);
      compare("first waddr", mas_model_inst.waddr_log[0], DBL_FIRST_WADDR);
      compare("last raddr1", mas_model_inst.raddr1_log[EXP_DBL_REQS - 1], DBL_LAST_RADDR1);
      compare("last raddr2", mas_model_inst.raddr2_log[EXP_DBL_REQS - 1], DBL_LAST_RADDR2);
      compare("last waddr", mas_model_inst.waddr_log[EXP_DBL_REQS - 1], DBL_LAST_WADDR);
      run_program(1'b1);
      compare("first raddr1", mas_model_inst.raddr1_log[0], ADD_FIRST_RADDR1);
      compare("first raddr2", mas_model_inst.raddr2_log[0], ADD_FIRST_RADDR2);
      compare("first waddr", mas_model_inst.waddr_log[0], ADD_FIRST_WADDR);
   endtask

   task automatic test_backpressure();
      run_program(1'b0);
      run_program(1'b1);
      assert (mas_model_inst.max_delay > 1) else begin
         $display("ERROR t=%0t: the MAS model never held a request back", $time);
         other_errs++;
      end
   endtask

   task automatic test_start_reset();
      launch(1'b0);
      wait_for_requests(5);
      start = 1'b1;   // ignored while the doubling run goes on
      ad    = 1'b1;
      next_cycle();
      start = 1'b0;
      ad    = 1'b0;
      wait_for_done();
      check_run(1'b0);
      launch(1'b1);
      wait_for_requests(8);
      reset_dut();
      run_program(1'b0);
   endtask

   initial begin
      cyc        = 0;
      trig_cyc   = 0;
      trig_pend  = 1'b0;
      done_count = 0;
      value_errs = 0;
      other_errs = 0;
      resetn     = 1'b0;
      start      = 1'b0;
      ad         = 1'b0;
      reset_dut();
      test_double();
      test_add();
      test_end_addresses();
      test_backpressure();
      test_start_reset();
      total_errs = value_errs + other_errs + mas_model_inst.err_count
                   + ecp_point_seq_inst.ecp_point_seq_asserts_inst.fail_count;
      $display("errors: value %0d, other %0d, MAS model %0d, assertions %0d", value_errs,
               other_errs, mas_model_inst.err_count,
               ecp_point_seq_inst.ecp_point_seq_asserts_inst.fail_count);
      if (total_errs == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("ERROR t=%0t: watchdog expired before the tests finished", $time);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
design/ecp_pkg.sv
design/ecp_step_rom.sv
design/ecp_seq_fsm.sv
design/ecp_point_seq.sv
dv/mas_model.sv
dv/ecp_point_seq_asserts.sv
dv/tb_ecp_point_seq.sv
